// ==== Bender.yml ====
package:
  name: cpu_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/alu.sv
      - logic/program_store.sv
      - logic/register_bank.sv
      - logic/data_ram.sv
      - logic/port_bridge.sv
      - logic/wide_controller.sv
      - logic/cpu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/cpu_tb.sv

// ==== filelist.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/alu.sv
logic/program_store.sv
logic/register_bank.sv
logic/data_ram.sv
logic/port_bridge.sv
logic/wide_controller.sv
logic/cpu_top.sv
tests/cpu_tb.sv

// ==== logic/alu.sv ====
// 8-bit alu

`include "cpu_consts.svh"

module alu (
    input  logic [`CPU_DATA_WIDTH-1:0] a_bus,
    input  logic [`CPU_DATA_WIDTH-1:0] b_bus,
    input  cpu_pkg::alu_op_e           alu_op,
    input  logic                       carry_in,
    output logic [`CPU_DATA_WIDTH-1:0] result,
    output cpu_pkg::flags_t            next_flags
);
    import cpu_pkg::*;

    localparam int W = `CPU_DATA_WIDTH;

    logic [W-1:0] add_b;
    logic         add_cin;
    logic [W:0]   sum;

    // one adder serves add, sub, inc and dec
    always_comb begin
        case (alu_op)
            ALU_ADDC: begin
                add_b   = b_bus;
                add_cin = carry_in;
            end
            ALU_SUB: begin
                add_b   = ~b_bus;
                add_cin = 1'b1;
            end
            ALU_INC: begin
                add_b   = W'(1);
                add_cin = 1'b0;
            end
            ALU_DEC: begin
                add_b   = ~W'(1);
                add_cin = 1'b1;
            end
            default: begin
                add_b   = b_bus;
                add_cin = 1'b0;
            end
        endcase
    end

    assign sum = {1'b0, a_bus} + {1'b0, add_b} + (W+1)'(add_cin);

    always_comb begin
        next_flags.carry    = 1'b0;
        next_flags.overflow = 1'b0;
        case (alu_op)
            ALU_PASS_A: result = a_bus;
            ALU_PASS_B: result = b_bus;
            ALU_ADD, ALU_ADDC, ALU_SUB, ALU_INC, ALU_DEC: begin
                result              = sum[W-1:0];
                // carry out doubles as no-borrow on subtract
                next_flags.carry    = sum[W];
                next_flags.overflow = (a_bus[W-1] == add_b[W-1]) && (sum[W-1] != a_bus[W-1]);
            end
            ALU_AND: result = a_bus & b_bus;
            ALU_OR:  result = a_bus | b_bus;
            ALU_XOR: result = a_bus ^ b_bus;
            ALU_SHL: begin
                result           = {a_bus[W-2:0], 1'b0};
                next_flags.carry = a_bus[W-1];
            end
            ALU_SHR: begin
                result           = {1'b0, a_bus[W-1:1]};
                next_flags.carry = a_bus[0];
            end
            default: result = a_bus;
        endcase
        next_flags.zero     = result == '0;
        next_flags.negative = result[W-1];
    end

endmodule

// ==== logic/cpu_consts.svh ====
// cpu core constants

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath byte width
`define CPU_DATA_WIDTH 8

// program counter and direct address width
`define CPU_PC_WIDTH 16

// memory sizes
`define CPU_PROG_DEPTH 256
`define CPU_RAM_DEPTH 256

// one instruction is six bytes
`define CPU_INSTR_WIDTH 48

// general purpose registers A to D
`define CPU_REG_COUNT 4

`endif

// ==== logic/cpu_pkg.sv ====
// cpu core types

`include "cpu_consts.svh"

package cpu_pkg;

    typedef enum logic [4:0] {
        ALU_PASS_A = 5'd0,
        ALU_PASS_B = 5'd1,
        ALU_ADD    = 5'd2,
        ALU_ADDC   = 5'd3,
        ALU_SUB    = 5'd4,
        ALU_AND    = 5'd5,
        ALU_OR     = 5'd6,
        ALU_XOR    = 5'd7,
        ALU_SHL    = 5'd8,
        ALU_SHR    = 5'd9,
        ALU_INC    = 5'd10,
        ALU_DEC    = 5'd11
    } alu_op_e;

    typedef enum logic [2:0] {
        ADEV_A    = 3'd0,
        ADEV_B    = 3'd1,
        ADEV_C    = 3'd2,
        ADEV_D    = 3'd3,
        ADEV_RAM  = 3'd4,
        ADEV_PORT = 3'd5,
        ADEV_ZERO = 3'd6
    } abus_dev_e;

    typedef enum logic [2:0] {
        BDEV_A     = 3'd0,
        BDEV_B     = 3'd1,
        BDEV_C     = 3'd2,
        BDEV_D     = 3'd3,
        BDEV_IMMED = 3'd4,
        BDEV_RAM   = 3'd5
    } bbus_dev_e;

    // codes 9 to 15 write nothing
    typedef enum logic [3:0] {
        TDEV_A    = 4'd0,
        TDEV_B    = 4'd1,
        TDEV_C    = 4'd2,
        TDEV_D    = 4'd3,
        TDEV_RAM  = 4'd4,
        TDEV_PORT = 4'd5,
        TDEV_PC   = 4'd6,
        TDEV_MAR  = 4'd7,
        TDEV_HALT = 4'd8,
        TDEV_NONE = 4'd9
    } targ_dev_e;

    typedef enum logic [2:0] {
        COND_ALWAYS = 3'd0,
        COND_ZERO   = 3'd1,
        COND_NZ     = 3'd2,
        COND_CARRY  = 3'd3,
        COND_NCARRY = 3'd4,
        COND_NEG    = 3'd5
    } cond_e;

    // top byte first, as the six ROMs were stacked
    typedef struct packed {
        alu_op_e                    alu_op;
        targ_dev_e                  targ_dev;
        abus_dev_e                  abus_dev;
        bbus_dev_e                  bbus_dev;
        logic                       spare_hi;
        cond_e                      cond;
        logic [3:0]                 spare_lo;
        logic                       amode;
        logic [`CPU_PC_WIDTH-1:0]   direct_addr;
        logic [`CPU_DATA_WIDTH-1:0] immed8;
    } instr_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic overflow;
    } flags_t;

    typedef struct packed {
        logic [7:0]                a_sel;
        logic [7:0]                b_sel;
        logic [`CPU_REG_COUNT-1:0] reg_we;
        logic                      mar_we;
        logic                      ram_we;
        alu_op_e                   alu_op;
        logic                      amode_direct;
        // stored carry for add with carry
        logic                      carry_in;
    } ctrl_t;

    typedef struct packed {
        logic                       write;
        logic [`CPU_DATA_WIDTH-1:0] data;
    } port_word_t;

endpackage

// ==== logic/cpu_top.sv ====
// cpu core top

`include "cpu_consts.svh"

module cpu_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               prog_we,
    input  logic [$clog2(`CPU_PROG_DEPTH)-1:0] prog_addr,
    input  logic [`CPU_INSTR_WIDTH-1:0]        prog_data,
    output logic                               port_req,
    output logic                               port_write,
    output logic [`CPU_DATA_WIDTH-1:0]         port_data_out,
    input  logic                               port_ack,
    input  logic [`CPU_DATA_WIDTH-1:0]         port_data_in,
    output logic                               halted
);
    import cpu_pkg::*;

    logic [`CPU_PC_WIDTH-1:0]   pc;
    instr_t                     instr;
    ctrl_t                      ctrl;
    flags_t                     next_flags;
    port_word_t                 port_req_word;
    logic                       port_start;
    logic                       port_done;
    logic [`CPU_DATA_WIDTH-1:0] a_bus;
    logic [`CPU_DATA_WIDTH-1:0] b_bus;
    logic [`CPU_DATA_WIDTH-1:0] result;
    logic [`CPU_DATA_WIDTH-1:0] ram_data;
    logic [`CPU_DATA_WIDTH-1:0] mar;
    logic [`CPU_DATA_WIDTH-1:0] port_data_in_q;

    wide_controller controller_i (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .result        (result),
        .next_flags    (next_flags),
        .port_done     (port_done),
        .pc            (pc),
        .ctrl          (ctrl),
        .port_start    (port_start),
        .port_req_word (port_req_word),
        .halted        (halted)
    );

    program_store program_store_i (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .instr     (instr)
    );

    alu alu_i (
        .a_bus      (a_bus),
        .b_bus      (b_bus),
        .alu_op     (ctrl.alu_op),
        .carry_in   (ctrl.carry_in),
        .result     (result),
        .next_flags (next_flags)
    );

    register_bank register_bank_i (
        .clk            (clk),
        .rst            (rst),
        .ctrl           (ctrl),
        .result         (result),
        .ram_data       (ram_data),
        .port_data_in_q (port_data_in_q),
        .immed8         (instr.immed8),
        .a_bus          (a_bus),
        .b_bus          (b_bus),
        .mar            (mar)
    );

    data_ram data_ram_i (
        .clk         (clk),
        .ctrl        (ctrl),
        .mar         (mar),
        .direct_addr (instr.direct_addr),
        .result      (result),
        .ram_data    (ram_data)
    );

    port_bridge port_bridge_i (
        .clk            (clk),
        .rst            (rst),
        .start          (port_start),
        .req_word       (port_req_word),
        .port_req       (port_req),
        .port_write     (port_write),
        .port_data_out  (port_data_out),
        .port_ack       (port_ack),
        .port_data_in   (port_data_in),
        .port_data_in_q (port_data_in_q),
        .done           (port_done)
    );

endmodule

// ==== logic/data_ram.sv ====
// data ram

`include "cpu_consts.svh"

module data_ram (
    input  logic                       clk,
    input  cpu_pkg::ctrl_t             ctrl,
    input  logic [`CPU_DATA_WIDTH-1:0] mar,
    input  logic [`CPU_PC_WIDTH-1:0]   direct_addr,
    input  logic [`CPU_DATA_WIDTH-1:0] result,
    output logic [`CPU_DATA_WIDTH-1:0] ram_data
);
    localparam int ADDR_W = $clog2(`CPU_RAM_DEPTH);

    logic [`CPU_DATA_WIDTH-1:0] mem [`CPU_RAM_DEPTH];
    logic [ADDR_W-1:0]          addr;

    // register mode goes through MAR
    assign addr = ctrl.amode_direct ? direct_addr[ADDR_W-1:0] : mar[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (ctrl.ram_we) begin
            mem[addr] <= result;
        end
    end

    assign ram_data = mem[addr];

endmodule

// ==== logic/port_bridge.sv ====
// four-phase port master

`include "cpu_consts.svh"

module port_bridge (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  cpu_pkg::port_word_t        req_word,
    output logic                       port_req,
    output logic                       port_write,
    output logic [`CPU_DATA_WIDTH-1:0] port_data_out,
    input  logic                       port_ack,
    input  logic [`CPU_DATA_WIDTH-1:0] port_data_in,
    output logic [`CPU_DATA_WIDTH-1:0] port_data_in_q,
    output logic                       done
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_WAIT_HI,
        BR_WAIT_LO
    } br_state_e;

    br_state_e  state_q;
    port_word_t word_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= BR_IDLE;
            port_req <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                BR_IDLE: begin
                    if (start) begin
                        port_req <= 1'b1;
                        state_q  <= BR_WAIT_HI;
                    end
                end
                BR_WAIT_HI: begin
                    if (port_ack) begin
                        port_req <= 1'b0;
                        state_q  <= BR_WAIT_LO;
                    end
                end
                BR_WAIT_LO: begin
                    // device released, finish next cycle
                    if (!port_ack) begin
                        done    <= 1'b1;
                        state_q <= BR_IDLE;
                    end
                end
                default: state_q <= BR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state_q == BR_IDLE) begin
            word_q <= req_word;
        end
        // input byte is valid while ack is high
        if (state_q == BR_WAIT_HI && port_ack && !word_q.write) begin
            port_data_in_q <= port_data_in;
        end
    end

    assign port_write    = word_q.write;
    assign port_data_out = word_q.data;

endmodule

// ==== logic/program_store.sv ====
// program store

`include "cpu_consts.svh"

module program_store (
    input  logic                                clk,
    input  logic                                prog_we,
    input  logic [$clog2(`CPU_PROG_DEPTH)-1:0]  prog_addr,
    input  cpu_pkg::instr_t                     prog_data,
    input  logic [`CPU_PC_WIDTH-1:0]            pc,
    output cpu_pkg::instr_t                     instr
);
    import cpu_pkg::*;

    localparam int ADDR_W = $clog2(`CPU_PROG_DEPTH);

    instr_t mem [`CPU_PROG_DEPTH];

    // loader port, usable while the core sits in reset
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // asynchronous fetch, upper pc bits ignored
    assign instr = mem[pc[ADDR_W-1:0]];

endmodule

// ==== logic/register_bank.sv ====
// register bank and operand buses

`include "cpu_consts.svh"

module register_bank (
    input  logic                       clk,
    input  logic                       rst,
    input  cpu_pkg::ctrl_t             ctrl,
    input  logic [`CPU_DATA_WIDTH-1:0] result,
    input  logic [`CPU_DATA_WIDTH-1:0] ram_data,
    input  logic [`CPU_DATA_WIDTH-1:0] port_data_in_q,
    input  logic [`CPU_DATA_WIDTH-1:0] immed8,
    output logic [`CPU_DATA_WIDTH-1:0] a_bus,
    output logic [`CPU_DATA_WIDTH-1:0] b_bus,
    output logic [`CPU_DATA_WIDTH-1:0] mar
);
    import cpu_pkg::*;

    logic [`CPU_DATA_WIDTH-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            mar <= '0;
        end else begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                if (ctrl.reg_we[i]) begin
                    regs[i] <= result;
                end
            end
            if (ctrl.mar_we) begin
                mar <= result;
            end
        end
    end

    // wired-or of one-hot selects, the zero source drives nothing
    always_comb begin
        a_bus = '0;
        b_bus = '0;
        for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            if (ctrl.a_sel[i]) a_bus |= regs[i];
            if (ctrl.b_sel[i]) b_bus |= regs[i];
        end
        if (ctrl.a_sel[ADEV_RAM])   a_bus |= ram_data;
        if (ctrl.a_sel[ADEV_PORT])  a_bus |= port_data_in_q;
        if (ctrl.b_sel[BDEV_IMMED]) b_bus |= immed8;
        if (ctrl.b_sel[BDEV_RAM])   b_bus |= ram_data;
    end

endmodule

// ==== logic/wide_controller.sv ====
// wide instruction controller

`include "cpu_consts.svh"

module wide_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  cpu_pkg::instr_t            instr,
    input  logic [`CPU_DATA_WIDTH-1:0] result,
    input  cpu_pkg::flags_t            next_flags,
    input  logic                       port_done,
    output logic [`CPU_PC_WIDTH-1:0]   pc,
    output cpu_pkg::ctrl_t             ctrl,
    output logic                       port_start,
    output cpu_pkg::port_word_t        port_req_word,
    output logic                       halted
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_PORT_WAIT,
        ST_HALTED
    } state_e;

    state_e      state_q;
    flags_t      flags_q;
    logic [15:0] tsel;
    logic        is_port;
    logic        is_halt;
    logic        retire;
    logic        take_jump;
    logic        flag_update;

    // target decode, two 3-to-8 decoders side by side
    assign tsel = 16'b1 << instr.targ_dev;

    assign is_port = (instr.abus_dev == ADEV_PORT) || (instr.targ_dev == TDEV_PORT);
    assign is_halt = instr.targ_dev == TDEV_HALT;

    // last cycle of a running instruction, nothing runs in reset
    assign retire = !rst
                 && (((state_q == ST_RUN) && !is_port && !is_halt)
                     || ((state_q == ST_PORT_WAIT) && port_done));

    // registers, MAR, RAM and port targets latch flags
    assign flag_update = (|tsel[5:0]) || tsel[TDEV_MAR];

    always_comb begin
        ctrl.a_sel = 8'b1 << instr.abus_dev;
        ctrl.b_sel = 8'b1 << instr.bbus_dev;
        for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            ctrl.reg_we[i] = retire && tsel[i];
        end
        ctrl.mar_we       = retire && tsel[TDEV_MAR];
        ctrl.ram_we       = retire && tsel[TDEV_RAM];
        ctrl.alu_op       = instr.alu_op;
        ctrl.amode_direct = instr.amode;
        ctrl.carry_in     = flags_q.carry;
    end

    // jumps test the stored flags, not this cycle's
    always_comb begin
        case (instr.cond)
            COND_ALWAYS: take_jump = 1'b1;
            COND_ZERO:   take_jump = flags_q.zero;
            COND_NZ:     take_jump = !flags_q.zero;
            COND_CARRY:  take_jump = flags_q.carry;
            COND_NCARRY: take_jump = !flags_q.carry;
            COND_NEG:    take_jump = flags_q.negative;
            default:     take_jump = 1'b0;
        endcase
    end

    assign port_start         = (state_q == ST_RUN) && is_port && !is_halt;
    assign port_req_word.write = instr.targ_dev == TDEV_PORT;
    assign port_req_word.data  = result;
    assign halted             = state_q == ST_HALTED;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_RUN;
            pc      <= '0;
            flags_q <= '0;
        end else begin
            case (state_q)
                ST_RUN: begin
                    if (is_halt) begin
                        state_q <= ST_HALTED;
                    end else if (is_port) begin
                        state_q <= ST_PORT_WAIT;
                    end
                end
                ST_PORT_WAIT: begin
                    if (port_done) begin
                        state_q <= ST_RUN;
                    end
                end
                default: state_q <= ST_HALTED;
            endcase
            if (retire) begin
                pc <= (tsel[TDEV_PC] && take_jump) ? instr.direct_addr : pc + 1'b1;
                if (flag_update) begin
                    flags_q <= next_flags;
                end
            end
        end
    end

endmodule

// ==== tests/cpu_tb.sv ====
// cpu core testbench

`include "cpu_consts.svh"

module cpu_tb;

    localparam int TD_DEPTH     = 512;
    localparam int RESET_CYCLES = 5;
    localparam int HALT_WATCH   = 50;
    localparam int PA_W         = $clog2(`CPU_PROG_DEPTH);
    localparam int DW           = `CPU_DATA_WIDTH;

    logic                         clk;
    logic                         rst;
    logic                         prog_we;
    logic [PA_W-1:0]              prog_addr;
    logic [`CPU_INSTR_WIDTH-1:0]  prog_data;
    logic                         port_req;
    logic                         port_write;
    logic [DW-1:0]                port_data_out;
    logic                         port_ack;
    logic [DW-1:0]                port_data_in;
    logic                         halted;

    // word 0 header, then program, input bytes, expected output bytes
    logic [`CPU_INSTR_WIDTH-1:0]  tdata [TD_DEPTH];

    int          prog_len;
    int          num_in;
    int          num_out;
    int          in_base;
    int          out_base;
    int          in_idx       = 0;
    int          out_idx      = 0;
    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycle_count  = 0;
    int          cycle_limit;
    logic [31:0] lcg_state    = 32'd47390;

    cpu_top cpu_top_i (
        .clk           (clk),
        .rst           (rst),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .port_req      (port_req),
        .port_write    (port_write),
        .port_data_out (port_data_out),
        .port_ack      (port_ack),
        .port_data_in  (port_data_in),
        .halted        (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // random ack delay of 0 to 7 cycles
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) & 32'd7);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        int n;
        n = errors - errors_before;
        tests_run++;
        if (n == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, n);
        end
    endtask

    // one four-phase transfer as the port device
    task automatic serve_transfer();
        int delay;
        do @(posedge clk); while (port_req !== 1'b1);
        delay = next_delay();
        // req has to hold until ack rises
        repeat (delay) begin
            @(posedge clk);
            check_value(port_req, 1'b1, "port_req dropped before ack");
        end
        if (port_write) begin
            if (out_idx < num_out) begin
                check_value(port_data_out, tdata[out_base + out_idx][DW-1:0],
                            $sformatf("output byte %0d", out_idx));
            end
            out_idx++;
        end else begin
            if (in_idx < num_in) begin
                port_data_in <= tdata[in_base + in_idx][DW-1:0];
            end else begin
                port_data_in <= '0;
            end
            in_idx++;
        end
        port_ack <= 1'b1;
        do @(posedge clk); while (port_req !== 1'b0);
        delay = next_delay();
        // no new request while ack is still high
        repeat (delay) begin
            @(posedge clk);
            check_value(port_req, 1'b0, "port_req rose while ack high");
        end
        port_ack <= 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= PA_W'(i);
            prog_data <= tdata[1 + i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    initial begin : port_device
        forever begin
            serve_transfer();
        end
    end

    // cycle budget from reset release until halt
    always @(posedge clk) begin
        if (rst === 1'b0 && halted !== 1'b1) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("timeout: the processor never halted within %0d cycles", cycle_limit);
                $display("Verification failed");
                $finish;
            end
        end
    end

    initial begin : main_sequence
        int errors_before;
        rst          = 1'b1;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        port_ack     = 1'b0;
        port_data_in = '0;

        $readmemh("tests/cpu_testdata.hex", tdata);
        prog_len    = tdata[0][47:32];
        num_in      = tdata[0][31:16];
        num_out     = tdata[0][15:0];
        in_base     = 1 + prog_len;
        out_base    = in_base + num_in;
        cycle_limit = 40 * prog_len + 20 * (num_in + num_out);

        // reset covers the load, then the reset cycles proper
        load_program();
        errors_before = errors;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            check_value(port_req, 1'b0, "port_req during reset");
            check_value(halted, 1'b0, "halted during reset");
        end
        rst <= 1'b0;
        repeat (2) begin
            @(posedge clk);
            check_value(port_req, 1'b0, "port_req after reset");
            check_value(halted, 1'b0, "halted after reset");
        end
        report_test("reset_state", errors_before);

        errors_before = errors;
        do @(posedge clk); while (halted !== 1'b1);
        report_test("program_run", errors_before);

        errors_before = errors;
        repeat (HALT_WATCH) begin
            @(posedge clk);
            check_value(halted, 1'b1, "halted dropped");
            check_value(port_req, 1'b0, "port_req after halt");
        end
        report_test("halt_hold", errors_before);

        errors_before = errors;
        check_value(in_idx, num_in, "input bytes taken");
        check_value(out_idx, num_out, "output bytes written");
        report_test("transfer_counts", errors_before);

        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tests/cpu_testdata.hex ====
// word 0: program length, input byte count, output byte count (16 bits each)
// then program words, input bytes, expected output bytes in port order
003500030014
// arithmetic, carry and logic ops
0868000000C8
100800000064
188800000010
028000000000
029000000000
096800000050
212800000070
21A800000020
183800000001
02A000000000
02B000000000
028000000000
0868000000F0
28880000003C
31080000000F
39880000005A
029000000000
02A000000000
02B000000000
400000000000
188800000000
490000000000
029000000000
02A000000000
// direct and MAR addressing
0A680100105A
0BE800000010
02C000000000
0BE800000020
0A68000000A5
02C001002000
086800000003
100A01001000
028000000000
// countdown loop and conditional jumps
096800000003
02A000000000
592000000000
030040002200
030060002700
02A000000000
592000000000
030060002B00
02A000000000
0300A0002C00
028000000000
// port reads, transform, write back, halt
505000000000
028000000000
38D8000000FF
029000000000
01D000000000
41B000000000
02B000000000
040000000000
028000000000
// input bytes
000000000041
00000000003C
000000000055
// expected output bytes
00000000002C
00000000003D
0000000000E0
0000000000C0
0000000000C2
000000000030
0000000000FF
0000000000AA
0000000000E1
000000000070
00000000005A
0000000000A5
00000000005D
000000000003
000000000002
000000000001
0000000000FF
000000000042
0000000000C3
0000000000AA
